// File: Makefile
RTL = design/rom_load_pkg.sv design/prog_if.sv design/dl_addr_map.sv \
      design/dl_writer.sv design/prom_bank.sv design/rom_fetch_arb.sv \
      design/rom_load_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module rom_load_top $(RTL)

sim:
	verilator --binary --assert -f vlog.f --top-module rom_load_tb \
		-Mdir obj_dir -o rom_load_tb
	./obj_dir/rom_load_tb

clean:
	rm -rf obj_dir

// File: design/dl_addr_map.sv
/*
 * Download address map
 * Decodes the region of a byte address and reorders address bits
 * so that graphics tiles land in whole SDRAM words
 */
`default_nettype none

module dl_addr_map (
    input  logic [rom_load_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [rom_load_pkg::PROG_AW-1:0]  pre_prog,
    output logic [rom_load_pkg::IOCTL_AW-1:0] pre_io,
    output logic [rom_load_pkg::PROG_AW-1:0]  prog_addr_mapped,
    output rom_load_pkg::region_e             io_region
);

    localparam int IAW = rom_load_pkg::IOCTL_AW;
    localparam int AW  = rom_load_pkg::PROG_AW;

    // Region limits in words
    localparam logic [AW-1:0] OBJ_WORD  = AW'(rom_load_pkg::OBJ_START >> 1);
    localparam logic [AW-1:0] PROM_WORD = AW'(rom_load_pkg::PROM_START >> 1);

    logic obj_word;

    always_comb begin
        if (ioctl_addr >= rom_load_pkg::PROM_START)      io_region = rom_load_pkg::REG_PROM;
        else if (ioctl_addr >= rom_load_pkg::OBJ_START)  io_region = rom_load_pkg::REG_OBJ;
        else if (ioctl_addr >= rom_load_pkg::SCR2_START) io_region = rom_load_pkg::REG_SCR2;
        else if (ioctl_addr >= rom_load_pkg::MAP2_START) io_region = rom_load_pkg::REG_MAP2;
        else                                             io_region = rom_load_pkg::REG_MAIN;
    end

    // Byte address reorder, before the byte to word step
    always_comb begin
        pre_io = ioctl_addr;
        case (io_region)
            rom_load_pkg::REG_MAP2: // Bit 6 becomes the low bit
                pre_io = {ioctl_addr[IAW-1:7], ioctl_addr[5:0], ioctl_addr[6]};
            rom_load_pkg::REG_SCR2: // Bits 7:6 drop to 2:1
                pre_io = {ioctl_addr[IAW-1:8], ioctl_addr[5:1], ioctl_addr[7:6], ioctl_addr[0]};
            default: ;
        endcase
    end

    assign obj_word = pre_prog >= OBJ_WORD && pre_prog < PROM_WORD;

    // OBJ words get bit 5 moved down to bit 1
    always_comb begin
        prog_addr_mapped = pre_prog;
        if (obj_word) begin
            prog_addr_mapped = {pre_prog[AW-1:6], pre_prog[4:1], pre_prog[5], pre_prog[0]};
        end
    end

endmodule

`default_nettype wire

// File: design/dl_writer.sv
/*
 * Download writer
 * Registers ioctl bytes and turns them into masked 16-bit SDRAM writes
 * held until acknowledged, or into PROM write pulses
 */
`default_nettype none

module dl_writer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              downloading,
    input  logic [rom_load_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                        ioctl_dout,
    input  logic                              ioctl_wr,
    input  logic                              sdram_ack,
    prog_if.writer                            prog
);

    localparam int AW = rom_load_pkg::PROG_AW;

    logic [rom_load_pkg::IOCTL_AW-1:0] pre_io;
    logic [AW-1:0]                     pre_prog;
    logic [AW-1:0]                     mapped;
    rom_load_pkg::region_e             io_region;
    logic                              strobe;
    logic                              is_prom;

    assign strobe   = downloading && ioctl_wr;
    assign is_prom  = io_region == rom_load_pkg::REG_PROM;
    assign pre_prog = pre_io[AW:1]; // Byte to word

    dl_addr_map u_map (
        .ioctl_addr       ( ioctl_addr ),
        .pre_prog         ( pre_prog   ),
        .pre_io           ( pre_io     ),
        .prog_addr_mapped ( mapped     ),
        .io_region        ( io_region  )
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog.prog_we <= 1'b0;
            prog.prom_we <= 1'b0;
        end else begin
            prog.prom_we <= strobe && is_prom; // Single cycle
            if (strobe && !is_prom) begin
                prog.prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog.prog_we <= 1'b0; // Drops after the ack cycle
            end
        end
    end

    // Payload is held while prog_we waits for the SDRAM
    always_ff @(posedge clk) begin
        if (strobe) begin
            prog.prog_data <= ioctl_dout;
            prog.prog_mask <= pre_io[0] ? 2'b01 : 2'b10; // Odd bytes go high
            if (is_prom) begin
                prog.prog_addr <= AW'(pre_io - rom_load_pkg::PROM_START);
            end else begin
                prog.prog_addr <= mapped;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/prog_if.sv
/*
 * Programming bus
 * One download write from the writer to the PROM banks and the top level
 */
`default_nettype none

interface prog_if;

    logic [rom_load_pkg::PROG_AW-1:0] prog_addr; // Word address, PROM byte offset
    logic [7:0]                       prog_data;
    logic [1:0]                       prog_mask; // Active low lane mask
    logic                             prog_we;   // Held until sdram_ack
    logic                             prom_we;   // One cycle pulse

    modport writer (output prog_addr, prog_data, prog_mask, prog_we, prom_we);

    modport sink (input prom_we, prog_addr, prog_data);

    modport mon (input prog_addr, prog_data, prog_mask, prog_we);

endinterface

`default_nettype wire

// File: design/prom_bank.sv
/*
 * PROM banks
 * On-chip colour and timing PROMs filled during the download,
 * read back one entry per cycle
 */
`default_nettype none

module prom_bank #(
    parameter int PROM_BANKS = 4,
    parameter int PROM_AW    = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    prog_if.sink                          prog,
    input  logic [$clog2(PROM_BANKS)-1:0] prom_rd_sel,
    input  logic [PROM_AW-1:0]            prom_rd_addr,
    output logic [7:0]                    prom_rd_data
);

    localparam int SW = $clog2(PROM_BANKS);

    // All banks in one array, bank number on top
    logic [7:0] mem [0:PROM_BANKS*(2**PROM_AW)-1];

    logic [3:0] wr_bank;
    logic       wr_en;

    assign wr_bank = prog.prog_addr[PROM_AW+3:PROM_AW];
    // Offsets past the last bank are dropped
    assign wr_en   = prog.prom_we && (int'(wr_bank) < PROM_BANKS);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_bank[SW-1:0], prog.prog_addr[PROM_AW-1:0]}] <= prog.prog_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prom_rd_data <= 8'd0;
        end else begin
            prom_rd_data <= mem[{prom_rd_sel, prom_rd_addr}]; // One cycle latency
        end
    end

endmodule

`default_nettype wire

// File: design/rom_fetch_arb.sv
/*
 * ROM fetch arbiter
 * Serves the main CPU and graphics slots from SDRAM, one request at a
 * time, with a one word cache and an ok level per slot
 */
`default_nettype none

module rom_fetch_arb (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             downloading,
    input  logic                             main_cs,
    input  logic [rom_load_pkg::SLOT_AW-1:0] main_addr,
    input  logic                             gfx_cs,
    input  logic [rom_load_pkg::SLOT_AW-1:0] gfx_addr,
    input  logic                             sdram_ack,
    input  logic                             data_rdy,
    input  logic [15:0]                      data_read,
    output logic                             main_ok,
    output logic [15:0]                      main_data,
    output logic                             gfx_ok,
    output logic [15:0]                      gfx_data,
    output logic                             sdram_req,
    output logic [rom_load_pkg::PROG_AW-1:0] sdram_addr
);

    localparam int AW  = rom_load_pkg::PROG_AW;
    localparam int SAW = rom_load_pkg::SLOT_AW;

    rom_load_pkg::arb_state_e state;

    // Index 0 is main, 1 is graphics
    logic [SAW-1:0] addr [2];
    logic [SAW-1:0] tag  [2]; // Address of the cached word
    logic [15:0]    dat  [2];
    logic [AW-1:0]  base [2];
    logic [1:0]     cs;
    logic [1:0]     vld;
    logic [1:0]     hit;
    logic [1:0]     need;
    logic           win;
    logic           sel;      // Slot being served
    logic           issue;
    logic           done;

    assign cs      = {gfx_cs, main_cs};
    assign addr[0] = main_addr;
    assign addr[1] = gfx_addr;
    assign base[0] = rom_load_pkg::MAIN_OFFSET;
    assign base[1] = rom_load_pkg::GFX_OFFSET;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i]  = vld[i] && (tag[i] == addr[i]);
            need[i] = cs[i] && !hit[i];
        end
    end

    assign win   = !need[0]; // Main wins ties
    assign issue = (state == rom_load_pkg::ARB_IDLE) && !downloading && (|need);
    assign done  = (state == rom_load_pkg::ARB_WAIT_DATA) && data_rdy;

    assign main_ok   = cs[0] && hit[0];
    assign gfx_ok    = cs[1] && hit[1];
    assign main_data = dat[0];
    assign gfx_data  = dat[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= rom_load_pkg::ARB_IDLE;
            sdram_req <= 1'b0;
            sel       <= 1'b0;
            vld       <= 2'b00;
        end else begin
            case (state)
                rom_load_pkg::ARB_IDLE: begin
                    if (issue) begin
                        state     <= rom_load_pkg::ARB_WAIT_ACK;
                        sdram_req <= 1'b1;
                        sel       <= win;
                    end
                end
                rom_load_pkg::ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        state     <= rom_load_pkg::ARB_WAIT_DATA;
                        sdram_req <= 1'b0;
                    end
                end
                rom_load_pkg::ARB_WAIT_DATA: begin
                    if (data_rdy) state <= rom_load_pkg::ARB_IDLE;
                end
                default: state <= rom_load_pkg::ARB_IDLE;
            endcase
            if (issue) vld[win] <= 1'b0; // Old word no longer trusted
            if (done) vld[sel] <= 1'b1;
            if (downloading) vld <= 2'b00; // SDRAM contents are changing
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            sdram_addr <= base[win] + AW'(addr[win]);
            tag[win]   <= addr[win];
        end
        if (done) dat[sel] <= data_read;
    end

endmodule

`default_nettype wire

// File: design/rom_load_pkg.sv
/*
 * ROM loading package
 * Download region map, bus widths and fetch slot offsets, plus the
 * enums shared by the download path and the SDRAM fetch arbiter
 */
`default_nettype none

package rom_load_pkg;

    localparam int IOCTL_AW = 25; // ioctl byte address
    localparam int PROG_AW  = 22; // SDRAM word address
    localparam int SLOT_AW  = 14; // Fetch slot word address

    // Byte start of each download region
    // Main code sits below MAP2_START
    localparam logic [IOCTL_AW-1:0] MAP2_START = 25'h000_0400;
    localparam logic [IOCTL_AW-1:0] SCR2_START = 25'h000_0800;
    localparam logic [IOCTL_AW-1:0] OBJ_START  = 25'h000_0c00;
    localparam logic [IOCTL_AW-1:0] PROM_START = 25'h000_1000; // Up to the end

    // Word offsets added by the arbiter to slot addresses
    localparam logic [PROG_AW-1:0] MAIN_OFFSET = '0;
    localparam logic [PROG_AW-1:0] GFX_OFFSET  = PROG_AW'(MAP2_START >> 1); // Tile map

    // Download regions
    typedef enum logic [2:0] {
        REG_MAIN,
        REG_MAP2,
        REG_SCR2,
        REG_OBJ,
        REG_PROM
    } region_e;

    // Fetch arbiter sequence
    typedef enum logic [1:0] {
        ARB_IDLE,      // Look for a slot with stale data
        ARB_WAIT_ACK,  // sdram_req held high
        ARB_WAIT_DATA  // Waiting on data_rdy
    } arb_state_e;

endpackage

`default_nettype wire

// File: design/rom_load_top.sv
/*
 * ROM load and fetch subsystem
 * ioctl download into SDRAM and PROM banks, then SDRAM reads
 * for the main CPU and graphics slots
 */
`default_nettype none

module rom_load_top #(
    parameter int PROM_BANKS = 4,
    parameter int PROM_AW    = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // ioctl download
    input  logic                              downloading,
    input  logic [rom_load_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                        ioctl_dout,
    input  logic                              ioctl_wr,
    // SDRAM programming
    output logic [rom_load_pkg::PROG_AW-1:0]  prog_addr,
    output logic [7:0]                        prog_data,
    output logic [1:0]                        prog_mask,
    output logic                              prog_we,
    output logic                              dwnld_busy,
    // SDRAM reads
    output logic                              sdram_req,
    output logic [rom_load_pkg::PROG_AW-1:0]  sdram_addr,
    input  logic                              sdram_ack,
    input  logic                              data_dst,
    input  logic                              data_rdy,
    input  logic [15:0]                       data_read,
    // Fetch slots
    input  logic                              main_cs,
    input  logic [rom_load_pkg::SLOT_AW-1:0]  main_addr,
    input  logic                              gfx_cs,
    input  logic [rom_load_pkg::SLOT_AW-1:0]  gfx_addr,
    output logic                              main_ok,
    output logic [15:0]                       main_data,
    output logic                              gfx_ok,
    output logic [15:0]                       gfx_data,
    // PROM readback
    input  logic [$clog2(PROM_BANKS)-1:0]     prom_rd_sel,
    input  logic [PROM_AW-1:0]                prom_rd_addr,
    output logic [7:0]                        prom_rd_data
);

    prog_if prog_bus ();

    assign dwnld_busy = downloading;

    // data_dst stays unconnected since a single client reads the SDRAM
    assign prog_addr = prog_bus.prog_addr;
    assign prog_data = prog_bus.prog_data;
    assign prog_mask = prog_bus.prog_mask;
    assign prog_we   = prog_bus.prog_we;

    dl_writer u_writer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog        ( prog_bus    )
    );

    prom_bank #(
        .PROM_BANKS ( PROM_BANKS ),
        .PROM_AW    ( PROM_AW    )
    ) u_prom (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .prog         ( prog_bus     ),
        .prom_rd_sel  ( prom_rd_sel  ),
        .prom_rd_addr ( prom_rd_addr ),
        .prom_rd_data ( prom_rd_data )
    );

    rom_fetch_arb u_arb (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .main_cs     ( main_cs     ),
        .main_addr   ( main_addr   ),
        .gfx_cs      ( gfx_cs      ),
        .gfx_addr    ( gfx_addr    ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .main_ok     ( main_ok     ),
        .main_data   ( main_data   ),
        .gfx_ok      ( gfx_ok      ),
        .gfx_data    ( gfx_data    ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  )
    );

endmodule

`default_nettype wire

// File: sim/rom_load_checker.sv
/*
 * Request protocol checker
 * Bound to the download writer and the fetch arbiter. A request is held
 * with a stable address until acked, then drops, and never overlaps a strobe
 */
`default_nettype none

module rom_load_checker (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             strobe,
    input logic                             req,
    input logic                             ack,
    input logic [rom_load_pkg::PROG_AW-1:0] addr
);

    int fail_cnt = 0; // Assertion failures so far

    // Held until the ack cycle
    a_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n) req && !ack |=> req
    ) else begin
        fail_cnt++;
        $error("request dropped before its ack");
    end

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n) req && !ack |=> $stable(addr)
    ) else begin
        fail_cnt++;
        $error("request address moved while waiting for ack");
    end

    // Drops in the cycle after the ack
    a_req_drop: assert property (
        @(posedge clk) disable iff (!rst_n) req && ack |=> !req
    ) else begin
        fail_cnt++;
        $error("request still high after its ack");
    end

    // Byte strobe on the writer, downloading on the arbiter
    a_quiet: assert property (
        @(posedge clk) disable iff (!rst_n) strobe |-> !req
    ) else begin
        fail_cnt++;
        $error("request high while the strobe input is active");
    end

endmodule

`default_nettype wire

// File: sim/rom_load_tb.sv
/*
 * ROM load testbench
 * Downloads bytes into every region, reads the PROMs back and fetches
 * through both slots from a behavioural SDRAM with random latency
 */
`default_nettype none

module rom_load_tb;

    localparam int AW  = rom_load_pkg::PROG_AW;
    localparam int IAW = rom_load_pkg::IOCTL_AW;
    localparam int SAW = rom_load_pkg::SLOT_AW;

    logic            clk;
    logic            rst_n;
    logic            downloading;
    logic [IAW-1:0]  ioctl_addr;
    logic [7:0]      ioctl_dout;
    logic            ioctl_wr;
    logic [AW-1:0]   prog_addr;
    logic [7:0]      prog_data;
    logic [1:0]      prog_mask;
    logic            prog_we;
    logic            dwnld_busy;
    logic            sdram_req;
    logic [AW-1:0]   sdram_addr;
    logic            sdram_ack;
    logic            data_dst;
    logic            data_rdy;
    logic [15:0]     data_read;
    logic            main_cs;
    logic [SAW-1:0]  main_addr;
    logic            gfx_cs;
    logic [SAW-1:0]  gfx_addr;
    logic            main_ok;
    logic [15:0]     main_data;
    logic            gfx_ok;
    logic [15:0]     gfx_data;
    logic [1:0]      prom_rd_sel;
    logic [7:0]      prom_rd_addr;
    logic [7:0]      prom_rd_data;

    logic [15:0]     sdram [0:4095];  // Behavioural SDRAM words
    logic [7:0]      prom_exp [0:1023];
    logic [9:0]      prom_list [$];
    logic [AW-1:0]   main_words [$];  // Slot addresses known to be written
    logic [AW-1:0]   gfx_words [$];
    integer          seed = 14;
    int              phase;
    int              cnt;
    logic            rd_kind;
    logic [11:0]     rd_addr;

    logic [IAW-1:0] byte_addrs [20] = '{
        25'h000, 25'h001, 25'h002, 25'h003, 25'h004, 25'h005, 25'h123, 25'h3ff,
        25'h400, 25'h440, 25'h441, 25'h47f, 25'h800, 25'h8c3, 25'h841, 25'h8be,
        25'hc20, 25'hc21, 25'hc3e, 25'hd35
    };
    logic [IAW-1:0] prom_addrs [7] = '{
        25'h1000, 25'h1001, 25'h10ff, 25'h1105, 25'h1210, 25'h13fe, 25'h1400
    };

    tb_clock #(.PERIOD(20), .RST_CYCLES(8)) clk_gen (.clk(clk), .rst_n(rst_n));

    rom_load_top dut_i (.*);

    bind dl_writer rom_load_checker chk_wr (
        .clk(clk), .rst_n(rst_n), .strobe(strobe),
        .req(prog.prog_we), .ack(sdram_ack), .addr(prog.prog_addr)
    );
    bind rom_fetch_arb rom_load_checker chk_rd (
        .clk(clk), .rst_n(rst_n), .strobe(downloading),
        .req(sdram_req), .ack(sdram_ack), .addr(sdram_addr)
    );

    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else stop_on_error($sformatf(
            "ERROR at %0t: %s expected %0h actual %0h", $time, name, exp, act));
    endtask

    // Byte address reorder of the graphics regions
    function automatic logic [IAW-1:0] pre_map(input logic [IAW-1:0] a);
        logic [IAW-1:0] p;
        p = a;
        if (a >= rom_load_pkg::MAP2_START && a < rom_load_pkg::SCR2_START) begin
            p[0] = a[6];
            for (int i = 0; i < 6; i++) p[i+1] = a[i];
        end else if (a >= rom_load_pkg::SCR2_START && a < rom_load_pkg::OBJ_START) begin
            p[2] = a[7];
            p[1] = a[6];
            for (int i = 1; i < 6; i++) p[i+2] = a[i];
        end
        return p;
    endfunction

    // Word address reorder of OBJ
    function automatic logic [AW-1:0] post_map(input logic [AW-1:0] w);
        logic [AW-1:0] m;
        m = w;
        if (w >= AW'(rom_load_pkg::OBJ_START >> 1) && w < AW'(rom_load_pkg::PROM_START >> 1)) begin
            m[1] = w[5];
            for (int i = 1; i < 5; i++) m[i+1] = w[i];
        end
        return m;
    endfunction

    function automatic bit listed(input logic [AW-1:0] q [$], input logic [AW-1:0] w);
        foreach (q[i]) if (q[i] == w) return 1'b1;
        return 1'b0;
    endfunction

    task automatic wait_prog_idle;
        int t;
        t = 0;
        while (prog_we) begin
            tick();
            t++;
            if (t > 50) stop_on_error("Timeout: prog_we was never released");
        end
    endtask

    task automatic send_byte(input logic [IAW-1:0] a, input logic [7:0] d);
        logic [IAW-1:0] p;
        logic [AW-1:0]  w;
        logic [11:0]    off;
        wait_prog_idle();
        p = pre_map(a);
        w = post_map(p[AW:1]);
        off = 12'(a - rom_load_pkg::PROM_START);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        tick();
        ioctl_wr   = 1'b0;
        if (a >= rom_load_pkg::PROM_START) begin
            check_eq("prog_we", 32'(0), 32'(prog_we));
            tick();
            check_eq("prog_we", 32'(0), 32'(prog_we));
            if (off[11:8] < 4'd4) begin
                prom_exp[off[9:0]] = d;
                prom_list.push_back(off[9:0]);
            end
        end else begin
            check_eq("prog_we", 32'(1), 32'(prog_we));
            check_eq("prog_addr", 32'(w), 32'(prog_addr));
            check_eq("prog_mask", p[0] ? 32'h1 : 32'h2, 32'(prog_mask));
            check_eq("prog_data", 32'(d), 32'(prog_data));
            if (w < AW'(rom_load_pkg::GFX_OFFSET)) begin
                if (!listed(main_words, w)) main_words.push_back(w);
            end else if (!listed(gfx_words, w - rom_load_pkg::GFX_OFFSET)) begin
                gfx_words.push_back(w - rom_load_pkg::GFX_OFFSET);
            end
            wait_prog_idle();
        end
    endtask

    // Both slots move to new addresses in the same cycle
    task automatic fetch_pair(input logic [AW-1:0] m, input logic [AW-1:0] g);
        int t;
        main_addr = SAW'(m);
        gfx_addr  = SAW'(g);
        main_cs   = 1'b1;
        gfx_cs    = 1'b1;
        tick();
        check_eq("main_ok", 32'(0), 32'(main_ok));
        check_eq("gfx_ok", 32'(0), 32'(gfx_ok));
        t = 0;
        while (!(main_ok && gfx_ok)) begin
            tick();
            t++;
            if (t > 100) stop_on_error("Timeout: a fetch slot never reported ok");
        end
        check_eq("main_data", 32'(sdram[12'(rom_load_pkg::MAIN_OFFSET + m)]), 32'(main_data));
        check_eq("gfx_data", 32'(sdram[12'(rom_load_pkg::GFX_OFFSET + g)]), 32'(gfx_data));
    endtask

    // Behavioural SDRAM acks after 1 to 4 cycles and raises data_rdy 1 to 3 cycles later
    initial begin
        for (int i = 0; i < 4096; i++) sdram[i] = 16'(i * 40503) ^ 16'h5a3c;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = 16'd0;
        phase     = 0;
        cnt       = 0;
        rd_kind   = 1'b0;
        rd_addr   = '0;
        forever begin
            tick();
            case (phase)
                0: if (prog_we || sdram_req) begin
                    rd_kind = !prog_we;
                    cnt     = 1 + int'($unsigned($random(seed)) % 4);
                    phase   = 1;
                end
                1: if (cnt > 1) begin
                    cnt--;
                end else begin
                    sdram_ack = 1'b1;
                    if (rd_kind) rd_addr = sdram_addr[11:0];
                    else if (prog_mask == 2'b10) sdram[prog_addr[11:0]][7:0] = prog_data;
                    else sdram[prog_addr[11:0]][15:8] = prog_data;
                    phase = 2;
                end
                2: begin
                    sdram_ack = 1'b0;
                    cnt       = 1 + int'($unsigned($random(seed)) % 3);
                    phase     = rd_kind ? 3 : 0;
                end
                3: if (cnt > 1) begin
                    cnt--;
                end else begin
                    data_rdy  = 1'b1;
                    data_read = sdram[rd_addr];
                    phase     = 4;
                end
                default: begin
                    data_rdy = 1'b0;
                    phase    = 0;
                end
            endcase
        end
    end

    initial begin
        int t;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_dout   = '0;
        ioctl_wr     = 1'b0;
        data_dst     = 1'b0;
        main_cs      = 1'b0;
        main_addr    = '0;
        gfx_cs       = 1'b0;
        gfx_addr     = '0;
        prom_rd_sel  = '0;
        prom_rd_addr = '0;
        t = 0;
        while (rst_n !== 1'b1) begin
            tick();
            t++;
            if (t > 20) stop_on_error("Timeout: reset never released");
        end
        tick();
        check_eq("prog_we", 32'(0), 32'(prog_we));
        check_eq("sdram_req", 32'(0), 32'(sdram_req));
        check_eq("main_ok", 32'(0), 32'(main_ok));
        check_eq("gfx_ok", 32'(0), 32'(gfx_ok));
        check_eq("dwnld_busy", 32'(0), 32'(dwnld_busy));
        downloading = 1'b1;
        main_cs     = 1'b1; // Slots want data while the download runs
        gfx_cs      = 1'b1;
        tick();
        check_eq("dwnld_busy", 32'(1), 32'(dwnld_busy));

        foreach (byte_addrs[i]) send_byte(byte_addrs[i], 8'($random(seed)));
        foreach (prom_addrs[i]) send_byte(prom_addrs[i], 8'($random(seed)));
        wait_prog_idle();
        main_cs     = 1'b0;
        gfx_cs      = 1'b0;
        downloading = 1'b0;
        tick();
        check_eq("dwnld_busy", 32'(0), 32'(dwnld_busy));

        foreach (prom_list[i]) begin
            prom_rd_sel  = prom_list[i][9:8];
            prom_rd_addr = prom_list[i][7:0];
            tick();
            check_eq("prom_rd_data", 32'(prom_exp[prom_list[i]]), 32'(prom_rd_data));
        end

        fetch_pair(main_words[0], gfx_words[0]);
        for (int k = 1; k <= 6; k++) begin
            fetch_pair(main_words[k % main_words.size()], gfx_words[k % gfx_words.size()]);
        end

        if (dut_i.u_writer.chk_wr.fail_cnt == 0 && dut_i.u_arb.chk_rd.fail_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_on_error("A protocol assertion in the bound checker failed");
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
/*
 * Testbench clock and reset
 * Free running clock and an active low reset held for a few cycles
 */
`default_nettype none

module tb_clock #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1; // Released just after an edge
    end

endmodule

`default_nettype wire

// File: vlog.f
design/rom_load_pkg.sv
design/prog_if.sv
design/dl_addr_map.sv
design/dl_writer.sv
design/prom_bank.sv
design/rom_fetch_arb.sv
design/rom_load_top.sv
sim/tb_clock.sv
sim/rom_load_checker.sv
sim/rom_load_tb.sv
